// ==== dcache_pkg.sv ====
package dcache_pkg;

    // ========================================
    // Cache geometry
    // ========================================
    localparam int num_ways   = 4;
    localparam int num_sets   = 16;
    localparam int index_w    = 4;
    localparam int offset_w   = 6;
    localparam int tag_w      = 22;
    localparam int line_bytes = 64;
    localparam int line_words = 16;

    typedef logic [line_bytes*8-1:0] line_t;
    typedef logic [num_ways-1:0]     way_t;

    // ========================================
    // Address and request
    // ========================================
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-3:0] word_off;
        logic [1:0]          byte_off;
    } addr_fields_t;

    // One address word, read either raw or split into its fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        logic        op;      // 0 is a load, 1 is a store
        cache_addr_u addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } cpu_req_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } fsm_state_t;

endpackage

// ==== dcache_main_fsm.sv ====
`timescale 1ns/1ps

module dcache_main_fsm (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              req_valid,
    input  logic                              op,
    input  logic [3:0]                        wstrb,
    input  logic [3:0]                        word_off,
    input  logic                              cache_hit,
    input  dcache_pkg::way_t                  hit_way,
    input  dcache_pkg::way_t                  victim_way,
    input  logic                              victim_dirty,
    input  logic                              rd_rdy,
    input  logic                              wr_rdy,
    input  logic                              fill_finish,
    output logic                              req_ready,
    output logic                              req_load,
    output logic                              victim_load,
    output dcache_pkg::way_t                  way_en,
    output logic [dcache_pkg::line_bytes-1:0] data_we,
    output logic                              tag_we,
    output logic                              dirty_we,
    output logic                              dirty_value,
    output logic                              fill_sel,
    output logic                              lru_touch,
    output logic                              rd_req,
    output logic                              wr_req,
    output logic                              rd_beat_ready,
    output logic                              data_valid
);

    dcache_pkg::fsm_state_t state, state_nxt;
    logic [dcache_pkg::line_bytes-1:0] hit_we;

    // Store strobes moved to their word inside the line
    assign hit_we = {{(dcache_pkg::line_bytes-4){1'b0}}, wstrb} << {word_off, 2'b00};

    assign req_load = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= dcache_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::idle: begin
                if (req_valid) state_nxt = dcache_pkg::lookup;
            end
            dcache_pkg::lookup: begin
                if (cache_hit) begin
                    state_nxt = req_valid ? dcache_pkg::lookup : dcache_pkg::idle;
                end else begin
                    state_nxt = victim_dirty ? dcache_pkg::miss : dcache_pkg::replace;
                end
            end
            dcache_pkg::miss: begin
                if (wr_rdy) state_nxt = dcache_pkg::replace;  // Victim line accepted
            end
            dcache_pkg::replace: begin
                if (rd_rdy) state_nxt = dcache_pkg::refill;
            end
            dcache_pkg::refill: begin
                if (fill_finish) state_nxt = dcache_pkg::idle;
            end
            default: state_nxt = dcache_pkg::idle;
        endcase
    end

    // ========================================
    // Strobes and levels
    // ========================================
    always_comb begin
        req_ready     = 1'b0;
        victim_load   = 1'b0;
        way_en        = '0;
        data_we       = '0;
        tag_we        = 1'b0;
        dirty_we      = 1'b0;
        dirty_value   = 1'b0;
        fill_sel      = 1'b0;
        lru_touch     = 1'b0;
        rd_req        = 1'b0;
        wr_req        = 1'b0;
        rd_beat_ready = 1'b0;
        data_valid    = 1'b0;
        case (state)
            dcache_pkg::idle: req_ready = 1'b1;
            dcache_pkg::lookup: begin
                if (cache_hit) begin
                    req_ready  = 1'b1;
                    data_valid = 1'b1;
                    way_en     = hit_way;
                    lru_touch  = 1'b1;
                    if (op) begin
                        data_we     = hit_we;
                        dirty_we    = 1'b1;
                        dirty_value = 1'b1;
                    end
                end else begin
                    victim_load = 1'b1;  // Save victim line and tag before it is replaced
                end
            end
            dcache_pkg::miss:    wr_req = 1'b1;
            dcache_pkg::replace: rd_req = 1'b1;
            dcache_pkg::refill: begin
                rd_beat_ready = 1'b1;
                if (fill_finish) begin
                    way_en      = victim_way;
                    data_we     = '1;
                    tag_we      = 1'b1;
                    dirty_we    = 1'b1;
                    dirty_value = op;  // A merged store leaves the new line dirty
                    fill_sel    = 1'b1;
                    lru_touch   = 1'b1;
                    data_valid  = 1'b1;
                end
            end
            default: ;
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        state inside {dcache_pkg::idle, dcache_pkg::lookup, dcache_pkg::miss,
                      dcache_pkg::replace, dcache_pkg::refill});

    a_one_mem_req: assert property (@(posedge clk) disable iff (!rstn)
        !(rd_req && wr_req));

endmodule

// ==== dcache_tag_store.sv ====
`timescale 1ns/1ps

module dcache_tag_store (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic [dcache_pkg::index_w-1:0]     index,
    input  logic [dcache_pkg::tag_w-1:0]       tag,
    input  dcache_pkg::way_t                   way_en,
    input  logic                               tag_we,
    input  logic                               dirty_we,
    input  logic                               dirty_value,
    input  dcache_pkg::way_t                   victim_way,
    output dcache_pkg::way_t                   hit_way,
    output logic                               cache_hit,
    output logic                               victim_dirty,
    output logic [dcache_pkg::tag_w-1:0]       victim_tag,
    output dcache_pkg::way_t                   valid_bits
);

    logic [dcache_pkg::tag_w-1:0] tags [dcache_pkg::num_sets][dcache_pkg::num_ways];
    dcache_pkg::way_t valid [dcache_pkg::num_sets];
    dcache_pkg::way_t dirty [dcache_pkg::num_sets];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < dcache_pkg::num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (tag_we) valid[index] <= valid[index] | way_en;
            if (dirty_we) begin
                dirty[index] <= dirty_value ? (dirty[index] | way_en)
                                            : (dirty[index] & ~way_en);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (tag_we && way_en[w]) tags[index][w] <= tag;
        end
    end

    // Compare all ways against the registered request tag
    always_comb begin
        victim_tag = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            hit_way[w] = valid[index][w] && (tags[index][w] == tag);
            if (victim_way[w]) victim_tag |= tags[index][w];
        end
    end

    assign cache_hit    = |hit_way;
    assign victim_dirty = |(dirty[index] & victim_way);
    assign valid_bits   = valid[index];

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(hit_way));

endmodule

// ==== dcache_data_store.sv ====
`timescale 1ns/1ps

module dcache_data_store (
    input  logic                                           clk,
    input  logic [dcache_pkg::index_w-1:0]                 index,
    input  dcache_pkg::way_t                               way_en,
    input  logic [dcache_pkg::line_bytes-1:0]              data_we,
    input  dcache_pkg::line_t                              wdata_line,
    output dcache_pkg::line_t [dcache_pkg::num_ways-1:0]   rd_lines
);

    dcache_pkg::line_t mem [dcache_pkg::num_ways][dcache_pkg::num_sets];

    // ========================================
    // Byte masked line write
    // ========================================
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (way_en[w]) begin
                for (int b = 0; b < dcache_pkg::line_bytes; b++) begin
                    if (data_we[b]) mem[w][index][b*8 +: 8] <= wdata_line[b*8 +: 8];
                end
            end
        end
    end

    // All ways are read at once so the hit and victim selects need no extra cycle
    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            rd_lines[w] = mem[w][index];
        end
    end

endmodule

// ==== dcache_plru.sv ====
`timescale 1ns/1ps

module dcache_plru (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [dcache_pkg::index_w-1:0] index,
    input  logic                           lru_touch,
    input  dcache_pkg::way_t               touch_way,
    input  dcache_pkg::way_t               valid_bits,
    output dcache_pkg::way_t               victim_way
);

    // Bit 0 picks the half, bit 1 picks in ways 0 and 1, bit 2 in ways 2 and 3
    logic [2:0] tree [dcache_pkg::num_sets];
    logic [1:0] touch_idx;
    logic [1:0] tree_idx;

    assign touch_idx = {touch_way[3] | touch_way[2], touch_way[3] | touch_way[1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < dcache_pkg::num_sets; s++) tree[s] <= '0;
        end else if (lru_touch) begin
            tree[index][0] <= !touch_idx[1];  // Point at the other half
            if (touch_idx[1]) tree[index][2] <= !touch_idx[0];
            else              tree[index][1] <= !touch_idx[0];
        end
    end

    assign tree_idx = tree[index][0] ? {1'b1, tree[index][2]} : {1'b0, tree[index][1]};

    always_comb begin
        victim_way = dcache_pkg::way_t'(1) << tree_idx;
        for (int w = dcache_pkg::num_ways - 1; w >= 0; w--) begin
            if (!valid_bits[w]) victim_way = dcache_pkg::way_t'(1) << w;  // Lowest empty way wins
        end
    end

endmodule

// ==== dcache_line_buffer.sv ====
`timescale 1ns/1ps

module dcache_line_buffer (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           req_load,
    input  dcache_pkg::cpu_req_t           req_in,
    input  logic                           victim_load,
    input  dcache_pkg::line_t              victim_line,
    input  logic [dcache_pkg::tag_w-1:0]   victim_tag,
    input  logic                           rd_beat_valid,
    input  logic [31:0]                    rd_beat_data,
    input  logic                           rd_beat_ready,
    input  dcache_pkg::line_t              hit_line,
    output dcache_pkg::cpu_req_t           req,
    output logic [31:0]                    wr_addr,
    output dcache_pkg::line_t              wr_line,
    output logic [31:0]                    rd_addr,
    output dcache_pkg::line_t              fill_line,
    output logic                           fill_finish,
    output logic [31:0]                    rdata
);

    logic [dcache_pkg::tag_w-1:0] wb_tag;
    logic [3:0]                   beat_cnt;
    logic                         beat_fire;
    logic [31:0]                  beat_buf [dcache_pkg::line_words];
    dcache_pkg::cache_addr_u      wb_a, rd_a;

    always_ff @(posedge clk) begin
        if (req_load) req <= req_in;
        if (victim_load) begin
            wr_line <= victim_line;
            wb_tag  <= victim_tag;
        end
    end

    // Line addresses always start at byte zero of the line
    always_comb begin
        rd_a            = req.addr;
        rd_a.f.word_off = '0;
        rd_a.f.byte_off = '0;
        wb_a            = rd_a;
        wb_a.f.tag      = wb_tag;
    end

    assign rd_addr = rd_a.raw;
    assign wr_addr = wb_a.raw;

    // ========================================
    // Refill beat collector
    // ========================================
    assign beat_fire   = rd_beat_valid && rd_beat_ready;
    assign fill_finish = beat_fire && (beat_cnt == 4'(dcache_pkg::line_words - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            beat_cnt <= beat_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire) beat_buf[beat_cnt] <= rd_beat_data;
    end

    always_comb begin
        for (int i = 0; i < dcache_pkg::line_words; i++) begin
            fill_line[i*32 +: 32] = beat_buf[i];
        end
        if (beat_fire) fill_line[beat_cnt*32 +: 32] = rd_beat_data;  // Last beat passes straight on
        if (req.op) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    fill_line[req.addr.f.word_off*32 + b*8 +: 8] = req.wdata[b*8 +: 8];
                end
            end
        end
    end

    assign rdata = rd_beat_ready ? fill_line[req.addr.f.word_off*32 +: 32]
                                 : hit_line[req.addr.f.word_off*32 +: 32];

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 req_ready,
    output logic                 data_valid,
    output logic [31:0]          rdata,
    output logic                 rd_req,
    output logic [31:0]          rd_addr,
    input  logic                 rd_rdy,
    input  logic                 rd_beat_valid,
    input  logic [31:0]          rd_beat_data,
    output logic                 rd_beat_ready,
    output logic                 wr_req,
    output logic [31:0]          wr_addr,
    output dcache_pkg::line_t    wr_line,
    input  logic                 wr_rdy
);

    dcache_pkg::cpu_req_t                       req_q;
    dcache_pkg::way_t                           hit_way, victim_way, way_en, valid_bits;
    dcache_pkg::line_t [dcache_pkg::num_ways-1:0] rd_lines;
    dcache_pkg::line_t                          hit_line, victim_line, fill_line;
    dcache_pkg::line_t                          store_line, wdata_line;
    logic [dcache_pkg::line_bytes-1:0]          data_we;
    logic [dcache_pkg::tag_w-1:0]               victim_tag;
    logic cache_hit, victim_dirty, req_load, victim_load, tag_we;
    logic dirty_we, dirty_value, fill_sel, lru_touch, fill_finish;

    // ========================================
    // Way selects and write data
    // ========================================
    always_comb begin
        hit_line    = '0;
        victim_line = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (hit_way[w])    hit_line    |= rd_lines[w];
            if (victim_way[w]) victim_line |= rd_lines[w];
        end
    end

    assign store_line = {dcache_pkg::line_words{req_q.wdata}};  // Byte enables pick the lanes
    assign wdata_line = fill_sel ? fill_line : store_line;

    dcache_main_fsm u_fsm (
        .clk, .rstn, .req_valid,
        .op(req_q.op), .wstrb(req_q.wstrb), .word_off(req_q.addr.f.word_off),
        .cache_hit, .hit_way, .victim_way, .victim_dirty, .rd_rdy, .wr_rdy, .fill_finish,
        .req_ready, .req_load, .victim_load, .way_en, .data_we, .tag_we, .dirty_we,
        .dirty_value, .fill_sel, .lru_touch, .rd_req, .wr_req, .rd_beat_ready, .data_valid
    );

    dcache_tag_store u_tags (
        .clk, .rstn, .index(req_q.addr.f.index), .tag(req_q.addr.f.tag),
        .way_en, .tag_we, .dirty_we, .dirty_value, .victim_way,
        .hit_way, .cache_hit, .victim_dirty, .victim_tag, .valid_bits
    );

    dcache_data_store u_data (
        .clk, .index(req_q.addr.f.index), .way_en, .data_we, .wdata_line, .rd_lines
    );

    dcache_plru u_plru (
        .clk, .rstn, .index(req_q.addr.f.index), .lru_touch, .touch_way(way_en),
        .valid_bits, .victim_way
    );

    dcache_line_buffer u_lbuf (
        .clk, .rstn, .req_load, .req_in(req), .victim_load, .victim_line, .victim_tag,
        .rd_beat_valid, .rd_beat_data, .rd_beat_ready, .hit_line,
        .req(req_q), .wr_addr, .wr_line, .rd_addr, .fill_line, .fill_finish, .rdata
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Reset is held low over the first 3 rising edges
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

    logic                 clk, rstn;
    logic                 req_valid;
    dcache_pkg::cpu_req_t req_in;
    logic                 req_ready, data_valid;
    logic [31:0]          rdata;
    logic                 rd_req, rd_rdy, rd_beat_valid, rd_beat_ready;
    logic [31:0]          rd_addr, rd_beat_data;
    logic                 wr_req, wr_rdy;
    logic [31:0]          wr_addr;
    dcache_pkg::line_t    wr_line;

    logic [31:0]       mem_words [logic [29:0]];  // Words that came back in written lines
    logic [31:0]       shadow [logic [29:0]];     // Every store the CPU made
    logic [31:0]       exp_rdata;
    dcache_pkg::line_t exp_wline;
    logic              cur_op, expect_hit, seen_accept, accept;
    logic [4:0]        beat_count;
    int                errors, n_reqs, wb_count, cycles;

    tb_clk_gen u_clk (.clk, .rstn);

    dcache_top uut (
        .clk, .rstn, .req_valid, .req(req_in), .req_ready, .data_valid, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .rd_beat_valid, .rd_beat_data, .rd_beat_ready,
        .wr_req, .wr_addr, .wr_line, .wr_rdy
    );

    assign accept = req_valid && req_ready;

    // ========================================
    // Reference memory and helpers
    // ========================================
    function automatic logic [31:0] init_word(logic [29:0] wa);
        return {wa, 2'b00} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [31:0] model_word(logic [29:0] wa);
        return mem_words.exists(wa) ? mem_words[wa] : init_word(wa);
    endfunction

    function automatic logic [31:0] shadow_word(logic [29:0] wa);
        return shadow.exists(wa) ? shadow[wa] : init_word(wa);
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wdata,
                                                logic [3:0] wstrb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] make_addr(int tag, int index, int word);
        dcache_pkg::cache_addr_u a;
        a.f.tag      = 22'(tag);
        a.f.index    = 4'(index);
        a.f.word_off = 4'(word);
        a.f.byte_off = 2'b00;
        return a.raw;
    endfunction

    task automatic cpu_access(input logic op, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wstrb,
                              input logic hit);
        logic [29:0] wa;
        wa = addr[31:2];
        @(negedge clk);
        req_valid       = 1'b1;
        req_in.op       = op;
        req_in.addr.raw = addr;
        req_in.wdata    = wdata;
        req_in.wstrb    = wstrb;
        expect_hit      = hit;
        while (!req_ready) @(negedge clk);
        // Taken at the next rising edge
        cur_op = op;
        if (op) shadow[wa] = merge_bytes(shadow_word(wa), wdata, wstrb);
        else    exp_rdata = shadow_word(wa);
        n_reqs++;
        @(negedge clk);
        req_valid  = 1'b0;
        expect_hit = 1'b0;
        while (!data_valid) @(negedge clk);  // Completion is stable mid-cycle
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            seen_accept <= 1'b0;
            beat_count  <= '0;
        end else begin
            if (accept) seen_accept <= 1'b1;
            if (rd_req && rd_rdy) beat_count <= '0;
            else if (rd_beat_valid && rd_beat_ready) beat_count <= beat_count + 5'd1;
        end
    end

    // ========================================
    // Memory model
    // ========================================
    initial begin
        logic [29:0] base;
        forever begin
            @(negedge clk);
            if (wr_req === 1'b1) begin
                for (int i = 0; i < 16; i++) begin
                    exp_wline[i*32 +: 32] = shadow_word(wr_addr[31:2] + 30'(i));
                end
                repeat ($urandom_range(5, 0)) @(negedge clk);
                wr_rdy = 1'b1;
                for (int i = 0; i < 16; i++) begin
                    mem_words[wr_addr[31:2] + 30'(i)] = wr_line[i*32 +: 32];
                end
                wb_count++;
                @(negedge clk);
                wr_rdy = 1'b0;
            end else if (rd_req === 1'b1) begin
                base = rd_addr[31:2];
                repeat ($urandom_range(5, 0)) @(negedge clk);
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int i = 0; i < 16; i++) begin
                    repeat ($urandom_range(5, 0)) @(negedge clk);  // Beats at any spacing
                    rd_beat_valid = 1'b1;
                    rd_beat_data  = model_word(base + 30'(i));
                    @(negedge clk);
                    rd_beat_valid = 1'b0;
                end
            end
        end
    end

    // ========================================
    // Checks
    // ========================================
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        !seen_accept |-> !rd_req && !wr_req && !data_valid)
        else begin
            errors++;
            $display("Memory request or completion seen before the first request");
        end

    a_read_data: assert property (@(posedge clk) disable iff (!rstn)
        data_valid && !cur_op |-> rdata == exp_rdata)
        else begin
            errors++;
            $display("Fail rdata: got %h, expected %h", $sampled(rdata), $sampled(exp_rdata));
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (!rstn)
        accept && expect_hit |=> data_valid && req_ready && !rd_req)
        else begin
            errors++;
            $display("A repeat access to a filled line did not complete one cycle later");
        end

    a_writeback_line: assert property (@(posedge clk) disable iff (!rstn)
        wr_req |-> wr_line == exp_wline)
        else begin
            errors++;
            $display("Fail wr_line at wr_addr %h: got %h, expected %h",
                     $sampled(wr_addr), $sampled(wr_line), $sampled(exp_wline));
        end

    a_line_addr: assert property (@(posedge clk) disable iff (!rstn)
        rd_req |-> rd_addr[5:0] == 6'd0)
        else begin
            errors++;
            $display("Fail rd_addr: %h has a nonzero line offset", $sampled(rd_addr));
        end

    a_wb_addr: assert property (@(posedge clk) disable iff (!rstn)
        wr_req |-> wr_addr[5:0] == 6'd0)
        else begin
            errors++;
            $display("Fail wr_addr: %h has a nonzero line offset", $sampled(wr_addr));
        end

    a_beat_count: assert property (@(posedge clk) disable iff (!rstn)
        data_valid && rd_beat_ready |-> beat_count == 5'd15 && rd_beat_valid)
        else begin
            errors++;
            $display("Refill completed without exactly 16 accepted beats");
        end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        req_valid     = 1'b0;
        req_in        = '0;
        rd_rdy        = 1'b0;
        rd_beat_valid = 1'b0;
        rd_beat_data  = '0;
        wr_rdy        = 1'b0;
        exp_rdata     = '0;
        exp_wline     = '0;
        cur_op        = 1'b0;
        expect_hit    = 1'b0;
        errors        = 0;
        n_reqs        = 0;
        wb_count      = 0;
        void'($urandom(85));
        @(posedge rstn);
        repeat (4) @(negedge clk);  // Idle with no request

        // Clean load miss, then a hit on the filled line
        cpu_access(1'b0, make_addr(1, 2, 3), 32'h0, 4'h0, 1'b0);
        cpu_access(1'b0, make_addr(1, 2, 7), 32'h0, 4'h0, 1'b1);

        // Store miss merged into the refill, then hits
        cpu_access(1'b1, make_addr(2, 2, 5), 32'h1234_5678, 4'b0110, 1'b0);
        cpu_access(1'b0, make_addr(2, 2, 5), 32'h0, 4'h0, 1'b1);
        cpu_access(1'b1, make_addr(2, 2, 5), 32'hcafe_f00d, 4'b1001, 1'b1);
        cpu_access(1'b0, make_addr(2, 2, 5), 32'h0, 4'h0, 1'b1);

        // Five dirty tags in set 5 force one line out
        for (int t = 0; t < 5; t++) begin
            cpu_access(1'b1, make_addr(40 + t, 5, t), 32'hd00d_0000 + 32'(t), 4'hf, 1'b0);
        end
        a_writeback_seen: assert (wb_count > 0)
            else begin
                errors++;
                $display("No dirty line was written back after the set overflowed");
            end
        for (int t = 0; t < 5; t++) begin
            cpu_access(1'b0, make_addr(40 + t, 5, t), 32'h0, 4'h0, 1'b0);
        end

        // Random traffic over six tags and four sets
        for (int n = 0; n < 150; n++) begin
            cpu_access(1'($urandom_range(1, 0)),
                       make_addr(int'($urandom_range(5, 0)), int'($urandom_range(3, 0)),
                                 int'($urandom_range(15, 0))),
                       $urandom, 4'($urandom_range(15, 0)), 1'b0);
        end

        repeat (4) @(negedge clk);
        $display("Requests %0d, write-backs %0d, errors %0d", n_reqs, wb_count, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // 200 requests at about 110 cycles for the slowest dirty miss, plus a margin
    initial begin
        cycles = 0;
        while (cycles < 200 * 110 + 500) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("Run stopped after %0d cycles without finishing", cycles);
        $display("Requests %0d, write-backs %0d, errors %0d", n_reqs, wb_count, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== flist.f ====
dcache_pkg.sv
dcache_main_fsm.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_plru.sv
dcache_line_buffer.sv
dcache_top.sv
tb_clk_gen.sv
tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    exit 1
fi
exit 0
